//--- hdl/renkon_pkg.sv
`default_nettype none

package renkon_pkg;

  // Datapath widths
  localparam int DWIDTH    = 16;
  localparam int DWIDTHLOG = 4;

  // Frame geometry, line buffers are sized from these
  localparam int IMG_W    = 8;
  localparam int IMG_H    = 8;
  localparam int COL_BITS = $clog2(IMG_W);
  localparam int ROW_BITS = $clog2(IMG_H);

  localparam int TAPS = 9;          // 3x3 window

  // Pixel strobe to output strobe, window + tree + activation
  localparam int CONV_LATENCY = 6;

  // Signed saturation limits
  localparam logic signed [DWIDTH-1:0] DATA_MAX = {1'b0, {(DWIDTH-1){1'b1}}};
  localparam logic signed [DWIDTH-1:0] DATA_MIN = {1'b1, {(DWIDTH-1){1'b0}}};

  typedef enum logic {
    ACT_NONE = 1'b0,
    ACT_RELU = 1'b1
  } act_op_e;

  typedef enum logic {
    WIN_IDLE   = 1'b0,
    WIN_STREAM = 1'b1
  } win_state_e;

  // Weights first so the address doubles as the tap index
  typedef enum logic [3:0] {
    CFG_W0, CFG_W1, CFG_W2, CFG_W3, CFG_W4, CFG_W5, CFG_W6, CFG_W7, CFG_W8,
    CFG_BIAS,
    CFG_QBITS,
    CFG_ACT
  } cfg_addr_e;

endpackage

`default_nettype wire

//--- hdl/renkon_window_if.sv
`default_nettype none

// One 3x3 window with its kernel, handed from decode to execute
interface renkon_window_if;

  logic                                  win_valid;  // Single-cycle strobe
  logic signed [renkon_pkg::DWIDTH-1:0]  pixel  [renkon_pkg::TAPS];
  logic signed [renkon_pkg::DWIDTH-1:0]  weight [renkon_pkg::TAPS];
  logic        [renkon_pkg::DWIDTHLOG-1:0] qbits;

  modport decode (
    output win_valid,
    output pixel,
    output weight,
    output qbits
  );

  modport execute (
    input win_valid,
    input pixel,
    input weight,
    input qbits
  );

endinterface

`default_nettype wire

//--- hdl/renkon_window.sv
`default_nettype none

module renkon_window (
  input  wire logic                                clk,
  input  wire logic                                xrst,
  input  wire logic                                cfg_we,
  input  wire renkon_pkg::cfg_addr_e               cfg_addr,
  input  wire logic signed [renkon_pkg::DWIDTH-1:0] cfg_data,
  input  wire logic                                frame_start,
  input  wire logic                                pixel_valid,
  input  wire logic signed [renkon_pkg::DWIDTH-1:0] pixel_in,
  renkon_window_if.decode                          win,
  output      logic signed [renkon_pkg::DWIDTH-1:0] bias,
  output      renkon_pkg::act_op_e                 act_op
);

  // Configuration registers
  logic signed [renkon_pkg::DWIDTH-1:0]    weight_q [renkon_pkg::TAPS];
  logic signed [renkon_pkg::DWIDTH-1:0]    bias_q;
  logic        [renkon_pkg::DWIDTHLOG-1:0] qbits_q;
  renkon_pkg::act_op_e                     act_q;

  // Two previous rows, lb1 is the older one
  logic signed [renkon_pkg::DWIDTH-1:0] lb0 [renkon_pkg::IMG_W];
  logic signed [renkon_pkg::DWIDTH-1:0] lb1 [renkon_pkg::IMG_W];

  logic signed [renkon_pkg::DWIDTH-1:0] tap_q   [renkon_pkg::TAPS];
  logic signed [renkon_pkg::DWIDTH-1:0] new_col [3];

  renkon_pkg::win_state_e                state_q;
  logic [renkon_pkg::COL_BITS-1:0]       col_q;
  logic [renkon_pkg::ROW_BITS-1:0]       row_q;
  logic                                  accept;
  logic                                  last_col;
  logic                                  last_row;
  logic                                  win_valid_q;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < renkon_pkg::TAPS; i++) begin
        weight_q[i] <= '0;
      end
      bias_q  <= '0;
      qbits_q <= '0;
      act_q   <= renkon_pkg::ACT_NONE;
    end else if (cfg_we) begin
      case (cfg_addr)
        renkon_pkg::CFG_BIAS:  bias_q  <= cfg_data;
        renkon_pkg::CFG_QBITS: qbits_q <= cfg_data[renkon_pkg::DWIDTHLOG-1:0];
        renkon_pkg::CFG_ACT:   act_q   <= renkon_pkg::act_op_e'(cfg_data[0]);
        default: begin
          if (cfg_addr <= renkon_pkg::CFG_W8) begin
            weight_q[cfg_addr] <= cfg_data;  // Address is the tap index
          end
        end
      endcase
    end
  end

  assign accept   = pixel_valid && (state_q == renkon_pkg::WIN_STREAM);
  assign last_col = (col_q == renkon_pkg::COL_BITS'(renkon_pkg::IMG_W - 1));
  assign last_row = (row_q == renkon_pkg::ROW_BITS'(renkon_pkg::IMG_H - 1));

  // Frame position, frame_start restarts even mid-frame
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_q <= renkon_pkg::WIN_IDLE;
      col_q   <= '0;
      row_q   <= '0;
    end else if (frame_start) begin
      state_q <= renkon_pkg::WIN_STREAM;
      col_q   <= '0;
      row_q   <= '0;
    end else if (accept) begin
      if (last_col) begin
        col_q <= '0;
        if (last_row) begin
          row_q   <= '0;
          state_q <= renkon_pkg::WIN_IDLE;  // Frame done
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // Column entering the window, top to bottom
  assign new_col[0] = lb1[col_q];
  assign new_col[1] = lb0[col_q];
  assign new_col[2] = pixel_in;

  always_ff @(posedge clk) begin
    if (accept) begin
      lb1[col_q] <= lb0[col_q];
      lb0[col_q] <= pixel_in;
    end
  end

  // Shift left by one column per pixel
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < renkon_pkg::TAPS; i++) begin
        tap_q[i] <= '0;
      end
      win_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        for (int r = 0; r < 3; r++) begin
          tap_q[3*r]     <= tap_q[3*r+1];
          tap_q[3*r+1]   <= tap_q[3*r+2];
          tap_q[3*r+2]   <= new_col[r];
        end
      end
      win_valid_q <= accept && (row_q >= 2) && (col_q >= 2);  // Full window only
    end
  end

  for (genvar i = 0; i < renkon_pkg::TAPS; i++) begin : g_lane
    assign win.pixel[i]  = tap_q[i];
    assign win.weight[i] = weight_q[i];
  end

  assign win.win_valid = win_valid_q;
  assign win.qbits     = qbits_q;
  assign bias          = bias_q;
  assign act_op        = act_q;

endmodule

`default_nettype wire

//--- hdl/renkon_conv_tree9.sv
`default_nettype none

module renkon_conv_tree9 (
  input  wire logic                                 clk,
  input  wire logic                                 xrst,
  renkon_window_if.execute                          win,
  output      logic                                 fmap_valid,
  output      logic signed [renkon_pkg::DWIDTH-1:0] fmap
);

  localparam int PW = 2 * renkon_pkg::DWIDTH;  // Full product width

  // Stage 1 input registers
  logic signed [renkon_pkg::DWIDTH-1:0]    px_q [renkon_pkg::TAPS];
  logic signed [renkon_pkg::DWIDTH-1:0]    wt_q [renkon_pkg::TAPS];
  logic        [renkon_pkg::DWIDTHLOG-1:0] qb1_q;

  // Stage 2 products
  logic signed [PW-1:0]                    prod_q [renkon_pkg::TAPS];
  logic        [renkon_pkg::DWIDTHLOG-1:0] qb2_q;

  // Stage 3 rounded products
  logic signed [renkon_pkg::DWIDTH-1:0] rnd_q [renkon_pkg::TAPS];

  // Stage 4 sum
  logic signed [renkon_pkg::DWIDTH-1:0] sum0 [4];
  logic signed [renkon_pkg::DWIDTH-1:0] sum1 [2];
  logic signed [renkon_pkg::DWIDTH-1:0] sum2;
  logic signed [renkon_pkg::DWIDTH-1:0] sum3;
  logic signed [renkon_pkg::DWIDTH-1:0] sum_q;

  logic [3:0] vld_q;

  // Shift down by qbits and take one more off negatives
  function automatic logic signed [renkon_pkg::DWIDTH-1:0] round_prod(
    input logic signed [PW-1:0]                    p,
    input logic        [renkon_pkg::DWIDTHLOG-1:0] q
  );
    logic signed [PW-1:0] shifted;
    shifted = p >>> q;
    if (p[PW-1]) begin
      shifted = shifted - 1;
    end
    return shifted[renkon_pkg::DWIDTH-1:0];
  endfunction

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < renkon_pkg::TAPS; i++) begin
        px_q[i]   <= '0;
        wt_q[i]   <= '0;
        prod_q[i] <= '0;
        rnd_q[i]  <= '0;
      end
      qb1_q <= '0;
      qb2_q <= '0;
    end else begin
      for (int i = 0; i < renkon_pkg::TAPS; i++) begin
        px_q[i]   <= win.pixel[i];
        wt_q[i]   <= win.weight[i];
        prod_q[i] <= px_q[i] * wt_q[i];               // Full width so no overflow
        rnd_q[i]  <= round_prod(prod_q[i], qb2_q);
      end
      qb1_q <= win.qbits;
      qb2_q <= qb1_q;  // Follows its window into rounding
    end
  end

  // Taps 0..7 pairwise and tap 8 last with wraparound
  for (genvar i = 0; i < 4; i++) begin : g_sum0
    assign sum0[i] = rnd_q[2*i] + rnd_q[2*i+1];
  end

  assign sum1[0] = sum0[0] + sum0[1];
  assign sum1[1] = sum0[2] + sum0[3];
  assign sum2    = sum1[0] + sum1[1];
  assign sum3    = sum2 + rnd_q[8];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      sum_q <= '0;
      vld_q <= '0;
    end else begin
      sum_q <= sum3;
      vld_q <= {vld_q[2:0], win.win_valid};  // One bit per stage
    end
  end

  assign fmap_valid = vld_q[3];
  assign fmap       = sum_q;

endmodule

`default_nettype wire

//--- hdl/renkon_activate.sv
`default_nettype none

module renkon_activate (
  input  wire logic                                 clk,
  input  wire logic                                 xrst,
  input  wire logic                                 fmap_valid,
  input  wire logic signed [renkon_pkg::DWIDTH-1:0] fmap,
  input  wire logic signed [renkon_pkg::DWIDTH-1:0] bias,
  input  wire renkon_pkg::act_op_e                  act_op,
  output      logic                                 out_valid,
  output      logic signed [renkon_pkg::DWIDTH-1:0] out_data
);

  localparam int DW = renkon_pkg::DWIDTH;

  logic signed [DW:0]   sum_wide;  // One guard bit
  logic signed [DW-1:0] sat;
  logic signed [DW-1:0] act;
  logic                 out_valid_q;
  logic signed [DW-1:0] out_data_q;

  assign sum_wide = {fmap[DW-1], fmap} + {bias[DW-1], bias};

  // Guard bit disagrees with sign bit on overflow
  always_comb begin
    if (sum_wide[DW] != sum_wide[DW-1]) begin
      sat = sum_wide[DW] ? renkon_pkg::DATA_MIN : renkon_pkg::DATA_MAX;
    end else begin
      sat = sum_wide[DW-1:0];
    end
  end

  always_comb begin
    if (act_op == renkon_pkg::ACT_RELU && sat[DW-1]) begin
      act = '0;
    end else begin
      act = sat;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_valid_q <= 1'b0;
      out_data_q  <= '0;
    end else begin
      out_valid_q <= fmap_valid;
      out_data_q  <= act;
    end
  end

  assign out_valid = out_valid_q;
  assign out_data  = out_data_q;

endmodule

`default_nettype wire

//--- hdl/renkon_conv_top.sv
`default_nettype none

// Streaming 3x3 convolution, window -> tree -> activation
module renkon_conv_top (
  input  wire logic                                 clk,
  input  wire logic                                 xrst,
  input  wire logic                                 cfg_we,
  input  wire renkon_pkg::cfg_addr_e                cfg_addr,
  input  wire logic signed [renkon_pkg::DWIDTH-1:0] cfg_data,
  input  wire logic                                 frame_start,
  input  wire logic                                 pixel_valid,
  input  wire logic signed [renkon_pkg::DWIDTH-1:0] pixel_in,
  output      logic                                 out_valid,
  output      logic signed [renkon_pkg::DWIDTH-1:0] out_data
);

  logic                                 fmap_valid;
  logic signed [renkon_pkg::DWIDTH-1:0] fmap;
  logic signed [renkon_pkg::DWIDTH-1:0] bias;    // Static during a frame
  renkon_pkg::act_op_e                  act_op;

  renkon_window_if win_if ();

  renkon_window u_window (
    .clk         (clk),
    .xrst        (xrst),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .frame_start (frame_start),
    .pixel_valid (pixel_valid),
    .pixel_in    (pixel_in),
    .win         (win_if.decode),
    .bias        (bias),
    .act_op      (act_op)
  );

  renkon_conv_tree9 u_tree (
    .clk        (clk),
    .xrst       (xrst),
    .win        (win_if.execute),
    .fmap_valid (fmap_valid),
    .fmap       (fmap)
  );

  renkon_activate u_activate (
    .clk        (clk),
    .xrst       (xrst),
    .fmap_valid (fmap_valid),
    .fmap       (fmap),
    .bias       (bias),
    .act_op     (act_op),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

endmodule

`default_nettype wire

//--- verif/renkon_clock_gen.sv
`default_nettype none

// Free-running testbench clock
module renkon_clock_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;  // 20 ns period

endmodule

`default_nettype wire

//--- verif/renkon_conv_sva.sv
`default_nettype none

// Checks on the convolution top level, tracks frame position on its own
module renkon_conv_sva (
  input wire logic                                 clk,
  input wire logic                                 xrst,
  input wire logic                                 frame_start,
  input wire logic                                 pixel_valid,
  input wire logic                                 out_valid,
  input wire logic signed [renkon_pkg::DWIDTH-1:0] out_data,
  input wire renkon_pkg::act_op_e                  act_op
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WINDOWS = (renkon_pkg::IMG_W - 2) * (renkon_pkg::IMG_H - 2);

  int   col;
  int   row;
  int   out_count;
  int   fail_count = 0;  // Polled by the testbench
  logic in_frame;
  logic seen_pixel;
  logic win_pix;
  logic frame_end;

  // Pixel strobe that completes a 3x3 window
  assign win_pix   = pixel_valid && in_frame && row >= 2 && col >= 2;
  assign frame_end = pixel_valid && in_frame && (row == renkon_pkg::IMG_H - 1)
                     && (col == renkon_pkg::IMG_W - 1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col        <= 0;
      row        <= 0;
      out_count  <= 0;
      in_frame   <= 1'b0;
      seen_pixel <= 1'b0;
    end else begin
      seen_pixel <= seen_pixel || pixel_valid;
      if (frame_start) begin
        col       <= 0;
        row       <= 0;
        out_count <= 0;
        in_frame  <= 1'b1;
      end else begin
        if (pixel_valid && in_frame) begin
          col <= (col == renkon_pkg::IMG_W - 1) ? 0 : col + 1;
          if (col == renkon_pkg::IMG_W - 1) begin
            row      <= (row == renkon_pkg::IMG_H - 1) ? 0 : row + 1;
            in_frame <= (row != renkon_pkg::IMG_H - 1);  // Last row closes the frame
          end
        end
        if (out_valid) begin
          out_count <= out_count + 1;
        end
      end
    end
  end

  a_reset_state: assert property (@(posedge clk) $rose(xrst) |-> !out_valid && out_data == '0)
    else begin
      $error("outputs not cleared when reset was released");
      fail_count++;
    end

  a_quiet_before_pixels: assert property (@(posedge clk) disable iff (!xrst)
    !seen_pixel |-> !out_valid)
    else begin
      $error("out_valid rose before any pixel was sent");
      fail_count++;
    end

  a_latency_fwd: assert property (@(posedge clk) disable iff (!xrst)
    win_pix |-> ##(renkon_pkg::CONV_LATENCY) out_valid)
    else begin
      $error("no output at the expected latency after a completing pixel");
      fail_count++;
    end

  a_latency_back: assert property (@(posedge clk) disable iff (!xrst)
    out_valid |-> $past(win_pix, renkon_pkg::CONV_LATENCY))
    else begin
      $error("output without a completing pixel at the expected latency");
      fail_count++;
    end

  a_frame_count: assert property (@(posedge clk) disable iff (!xrst)
    frame_end |-> ##(renkon_pkg::CONV_LATENCY + 1) out_count == WINDOWS)
    else begin
      $error("frame did not produce the expected number of outputs");
      fail_count++;
    end

  a_relu_sign: assert property (@(posedge clk) disable iff (!xrst)
    out_valid && act_op == renkon_pkg::ACT_RELU |-> !out_data[renkon_pkg::DWIDTH-1])
    else begin
      $error("negative output while ReLU is selected");
      fail_count++;
    end

endmodule

bind renkon_conv_top renkon_conv_sva u_sva (
  .clk         (clk),
  .xrst        (xrst),
  .frame_start (frame_start),
  .pixel_valid (pixel_valid),
  .out_valid   (out_valid),
  .out_data    (out_data),
  .act_op      (act_op)
);

`default_nettype wire

//--- verif/renkon_conv_tb.sv
`default_nettype none

module renkon_conv_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW    = renkon_pkg::DWIDTH;
  localparam int W     = renkon_pkg::IMG_W;
  localparam int H     = renkon_pkg::IMG_H;
  localparam int MAX_V = 2 ** (DW - 1) - 1;
  localparam int MIN_V = -(2 ** (DW - 1));
  // Four full frames and a partial one at about 70 cycles, plus reset and config
  localparam int TIMEOUT_CYCLES = 5 * 70 + 100;

  logic                  clk;
  logic                  xrst;
  logic                  cfg_we;
  renkon_pkg::cfg_addr_e cfg_addr;
  logic signed [DW-1:0]  cfg_data;
  logic                  frame_start;
  logic                  pixel_valid;
  logic signed [DW-1:0]  pixel_in;
  logic                  out_valid;
  logic signed [DW-1:0]  out_data;

  // Model copy of frame and configuration
  logic signed [DW-1:0]  img [H][W];
  logic signed [DW-1:0]  kern [renkon_pkg::TAPS];
  logic signed [DW-1:0]  bias_v;
  int                    qbits_v;
  renkon_pkg::act_op_e   act_v;
  logic signed [DW-1:0]  exp_q [$];
  logic signed [DW-1:0]  expected;
  integer                seed = 6488;
  int                    cycles = 0;

  renkon_clock_gen u_clock_gen (.clk(clk));

  renkon_conv_top u_renkon_conv_top (.*);

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic logic signed [DW-1:0] rand16();
    logic [31:0] r;
    r = $random(seed);
    return r[DW-1:0];
  endfunction

  // Expected output for the window whose bottom-right pixel is (r, c)
  function automatic logic signed [DW-1:0] model_out(input int r, input int c);
    longint               prod;
    longint               scaled;
    logic signed [DW-1:0] acc;
    int                   total;
    acc = '0;
    for (int k = 0; k < renkon_pkg::TAPS; k++) begin
      prod   = longint'(img[r - 2 + k / 3][c - 2 + k % 3]) * longint'(kern[k]);
      scaled = prod >>> qbits_v;
      if (prod < 0) begin
        scaled = scaled - 1;  // Negative products lose one more
      end
      acc = acc + scaled[DW-1:0];  // Wraps at DWIDTH
    end
    total = int'(acc) + int'(bias_v);
    total = (total > MAX_V) ? MAX_V : (total < MIN_V) ? MIN_V : total;
    if (act_v == renkon_pkg::ACT_RELU && total < 0) begin
      total = 0;
    end
    return total[DW-1:0];
  endfunction

  // 0 small positive, 1 full range, 2 large negative, 3 large positive mixed
  task automatic fill_image(input int mode);
    logic signed [DW-1:0] r;
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        r = rand16();
        case (mode)
          0:       img[y][x] = r & 16'sh03ff;
          1:       img[y][x] = r;
          2:       img[y][x] = -16'sd20000 - (r & 16'sh1fff);
          default: img[y][x] = (x % 2 == 0) ? 16'sd20000 + (r & 16'sh1fff) : r;
        endcase
      end
    end
  endtask

  task automatic write_cfg(input renkon_pkg::cfg_addr_e addr, input logic signed [DW-1:0] data);
    @(posedge clk);
    cfg_we   <= 1'b1;
    cfg_addr <= addr;
    cfg_data <= data;
  endtask

  task automatic idle_bus();
    @(posedge clk);
    cfg_we      <= 1'b0;
    frame_start <= 1'b0;
    pixel_valid <= 1'b0;
  endtask

  task automatic load_config();
    for (int i = 0; i < renkon_pkg::TAPS; i++) begin
      write_cfg(renkon_pkg::cfg_addr_e'(i), kern[i]);  // Weight address is the tap
    end
    write_cfg(renkon_pkg::CFG_BIAS, bias_v);
    write_cfg(renkon_pkg::CFG_QBITS, DW'(qbits_v));
    write_cfg(renkon_pkg::CFG_ACT, DW'(act_v));
    idle_bus();
  endtask

  // Streams the first n_pix pixels of img and waits for all outputs
  task automatic stream_frame(input int n_pix);
    for (int i = 0; i < n_pix; i++) begin
      if (i / W >= 2 && i % W >= 2) begin
        exp_q.push_back(model_out(i / W, i % W));
      end
    end
    @(posedge clk);
    frame_start <= 1'b1;
    for (int i = 0; i < n_pix; i++) begin
      @(posedge clk);
      frame_start <= 1'b0;
      pixel_valid <= 1'b1;
      pixel_in    <= img[i / W][i % W];
    end
    idle_bus();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);  // Frame count check lands after the last output
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_now($sformatf("timeout, run still busy after %0d cycles", cycles));
    end else if (u_renkon_conv_top.u_sva.fail_count != 0) begin
      fail_now("a bound assertion on the DUT failed");
    end else if (xrst && out_valid) begin
      if (exp_q.size() == 0) begin
        fail_now("out_valid came while no output was expected");
      end else begin
        expected = exp_q.pop_front();
        assert (out_data == expected) else begin
          fail_now($sformatf("[FAIL] %0t ns out_data expected %0d actual %0d",
                             $time, expected, out_data));
        end
      end
    end
  end

  initial begin
    xrst        = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = renkon_pkg::CFG_W0;
    cfg_data    = '0;
    frame_start = 1'b0;
    pixel_valid = 1'b0;
    pixel_in    = '0;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;

    // Identity kernel, center weight 1 << qbits
    kern    = '{default: '0};
    kern[4] = 16'sd8;
    qbits_v = 3;
    bias_v  = '0;
    act_v   = renkon_pkg::ACT_NONE;
    load_config();
    fill_image(0);
    stream_frame(W * H);

    for (int i = 0; i < renkon_pkg::TAPS; i++) begin
      kern[i] = rand16();
    end
    qbits_v = 4;
    bias_v  = 16'sd37;
    load_config();
    fill_image(1);
    stream_frame(W * H);

    act_v = renkon_pkg::ACT_RELU;  // Same frame again
    write_cfg(renkon_pkg::CFG_ACT, DW'(act_v));
    idle_bus();
    stream_frame(W * H);

    // Three rows low-saturating, then restart high-saturating
    kern    = '{default: '0};
    kern[4] = 16'sd1;
    qbits_v = 0;
    bias_v  = -16'sd30000;
    act_v   = renkon_pkg::ACT_NONE;
    load_config();
    fill_image(2);
    stream_frame(3 * W);
    bias_v = 16'sd30000;
    write_cfg(renkon_pkg::CFG_BIAS, bias_v);
    idle_bus();
    fill_image(3);
    stream_frame(W * H);

    if (u_renkon_conv_top.u_sva.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      fail_now("a bound assertion on the DUT failed");
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/renkon_pkg.sv
hdl/renkon_window_if.sv
hdl/renkon_window.sv
hdl/renkon_conv_tree9.sv
hdl/renkon_activate.sv
hdl/renkon_conv_top.sv
verif/renkon_clock_gen.sv
verif/renkon_conv_sva.sv
verif/renkon_conv_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module renkon_conv_tb \
  -f verilog.f -Mdir obj_dir -o renkon_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

# Error limit raised so the testbench reports bound assertion failures itself
{ ./obj_dir/renkon_sim +verilator+error+limit+100 > sim.log 2>&1 || true; } \
  && grep -qx "test passed" sim.log \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL, see sim.log"; exit 1; }
